// File: verilog/riscvPkg.sv
/*
 * RV32I core shared definitions
 * Machine word type, major opcodes and the control select encodings
 * passed between the decoder, datapath and immediate generator.
 */

package riscvPkg;

    typedef logic [31:0] wordT;

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0]
    {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LOAD   = 7'b0000011
    } opcodeT;

    // ALU operation class
    typedef enum logic [1:0]
    {
        ALU_ADD   = 2'b00,
        ALU_SUB   = 2'b01,
        ALU_FUNCT = 2'b10
    } aluOpT;

    // Writeback source
    typedef enum logic [1:0]
    {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10,
        RES_IMM = 2'b11
    } resultSrcT;

    // Next-PC source
    typedef enum logic [1:0]
    {
        PC_SEQ    = 2'b00,
        PC_BRANCH = 2'b01,
        PC_JAL    = 2'b10,
        PC_JALR   = 2'b11
    } pcSrcT;

    typedef enum logic [2:0]
    {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } immTypeT;

endpackage

// File: verilog/controlUnit.sv
/*
 * Main decoder of the single-cycle core
 * Turns the major opcode and func3 into the datapath selects and the
 * write and read enables. Unknown encodings decode as a no-op.
 */

`timescale 1ns/1ps

module controlUnit
(
    input  riscvPkg::opcodeT    opcode,
    input  logic [2:0]          func3,
    output riscvPkg::resultSrcT resultSrc,
    output riscvPkg::pcSrcT     pcSrc,
    output logic                aluSrcA,
    output logic                aluSrcB,
    output riscvPkg::immTypeT   immType,
    output riscvPkg::aluOpT     aluOp,
    output logic                memWrite,
    output logic                memRead,
    output logic                regWrite,
    output logic                branchNotEqual
);

    always_comb
    begin
        // No-op defaults, each class overrides what it needs
        resultSrc      = riscvPkg::RES_ALU;
        pcSrc          = riscvPkg::PC_SEQ;
        aluSrcA        = 1'b0;
        aluSrcB        = 1'b0;
        immType        = riscvPkg::IMM_I;
        aluOp          = riscvPkg::ALU_ADD;
        memWrite       = 1'b0;
        memRead        = 1'b0;
        regWrite       = 1'b0;
        branchNotEqual = 1'b0;

        case (opcode)
            riscvPkg::OP:
            begin
                aluOp    = riscvPkg::ALU_FUNCT;
                regWrite = 1'b1;
            end
            riscvPkg::OP_IMM:
            begin
                aluOp    = riscvPkg::ALU_FUNCT;
                aluSrcB  = 1'b1;
                regWrite = 1'b1;
            end
            riscvPkg::LOAD:
            begin
                aluSrcB   = 1'b1;
                resultSrc = riscvPkg::RES_MEM;
                memRead   = 1'b1;
                regWrite  = 1'b1;
            end
            riscvPkg::STORE:
            begin
                aluSrcB  = 1'b1;
                immType  = riscvPkg::IMM_S;
                memWrite = 1'b1;
            end
            riscvPkg::BRANCH:
            begin
                // Only BEQ and BNE, other func3 values stay a no-op
                if (func3 == 3'b000 || func3 == 3'b001)
                begin
                    pcSrc          = riscvPkg::PC_BRANCH;
                    immType        = riscvPkg::IMM_B;
                    aluOp          = riscvPkg::ALU_SUB;
                    branchNotEqual = func3[0];
                end
            end
            riscvPkg::LUI:
            begin
                immType   = riscvPkg::IMM_U;
                resultSrc = riscvPkg::RES_IMM;
                regWrite  = 1'b1;
            end
            riscvPkg::AUIPC:
            begin
                aluSrcA  = 1'b1;
                aluSrcB  = 1'b1;
                immType  = riscvPkg::IMM_U;
                regWrite = 1'b1;
            end
            riscvPkg::JAL:
            begin
                pcSrc     = riscvPkg::PC_JAL;
                immType   = riscvPkg::IMM_J;
                resultSrc = riscvPkg::RES_PC4;
                regWrite  = 1'b1;
            end
            riscvPkg::JALR:
            begin
                // Target comes out of the ALU as rs1 + imm
                pcSrc     = riscvPkg::PC_JALR;
                aluSrcB   = 1'b1;
                resultSrc = riscvPkg::RES_PC4;
                regWrite  = 1'b1;
            end
            default:
            begin
                pcSrc = riscvPkg::PC_SEQ;
            end
        endcase
    end

endmodule

// File: verilog/alu.sv
/*
 * Integer ALU
 * Picks the operation from the class given by the decoder, or from
 * func3 and the func7 bit for arithmetic instructions.
 */

`timescale 1ns/1ps

module alu
(
    input  riscvPkg::aluOpT aluOp,
    input  logic [2:0]      func3,
    input  logic            func7Bit,
    input  logic            operandImm,
    input  riscvPkg::wordT  a,
    input  riscvPkg::wordT  b,
    output riscvPkg::wordT  result,
    output logic            zero
);

    typedef enum logic [3:0]
    {
        F_ADD,
        F_SUB,
        F_AND,
        F_OR,
        F_XOR,
        F_SLT,
        F_SLTU,
        F_SLL,
        F_SRL,
        F_SRA
    } aluFuncT;

    aluFuncT    func;
    logic [4:0] shamt;

    assign shamt = b[4:0];

    // Operation decode
    always_comb
    begin
        func = F_ADD;
        case (aluOp)
            riscvPkg::ALU_ADD:   func = F_ADD;
            riscvPkg::ALU_SUB:   func = F_SUB;
            riscvPkg::ALU_FUNCT:
            begin
                case (func3)
                    // Immediate forms have no subtract
                    3'b000:  func = (func7Bit && !operandImm) ? F_SUB : F_ADD;
                    3'b001:  func = F_SLL;
                    3'b010:  func = F_SLT;
                    3'b011:  func = F_SLTU;
                    3'b100:  func = F_XOR;
                    3'b101:  func = func7Bit ? F_SRA : F_SRL;
                    3'b110:  func = F_OR;
                    default: func = F_AND;
                endcase
            end
            default:             func = F_ADD;
        endcase
    end

    always_comb
    begin
        case (func)
            F_SUB:   result = a - b;
            F_AND:   result = a & b;
            F_OR:    result = a | b;
            F_XOR:   result = a ^ b;
            F_SLT:   result = {31'b0, $signed(a) < $signed(b)};
            F_SLTU:  result = {31'b0, a < b};
            F_SLL:   result = a << shamt;
            F_SRL:   result = a >> shamt;
            F_SRA:   result = $signed(a) >>> shamt;
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: verilog/registerFile.sv
/*
 * Integer register file, 32 x 32
 * Two combinational read ports and one write port on the clock edge.
 * x0 reads as zero and ignores writes.
 */

`timescale 1ns/1ps

module registerFile
(
    input  logic           clk,
    input  logic           reset,
    input  logic [4:0]     readAddr1,
    input  logic [4:0]     readAddr2,
    output riscvPkg::wordT readData1,
    output riscvPkg::wordT readData2,
    input  logic [4:0]     writeAddr,
    input  riscvPkg::wordT writeData,
    input  logic           writeEnable
);

    // x1 to x31 only
    riscvPkg::wordT regs [1:31];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (writeEnable && writeAddr != 5'd0)
        begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readData1 = (readAddr1 == 5'd0) ? '0 : regs[readAddr1];
    assign readData2 = (readAddr2 == 5'd0) ? '0 : regs[readAddr2];

endmodule

// File: verilog/immediateGen.sv
/*
 * Immediate generator
 * Collects the immediate bits of the I, S, B, U and J formats and
 * sign-extends them to a full word.
 */

`timescale 1ns/1ps

module immediateGen
(
    input  riscvPkg::wordT    instr,
    input  riscvPkg::immTypeT immType,
    output riscvPkg::wordT    imm
);

    always_comb
    begin
        case (immType)
            riscvPkg::IMM_S:
            begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            riscvPkg::IMM_B:
            begin
                // Bit 0 is always zero for branch offsets
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            riscvPkg::IMM_U:
            begin
                imm = {instr[31:12], 12'b0};
            end
            riscvPkg::IMM_J:
            begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default:
            begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
        endcase
    end

endmodule

// File: verilog/riscvCore.sv
/*
 * Single-cycle RV32I subset core
 * Fetches, decodes, executes and retires one instruction per clock.
 * Instruction and data memories are external and answer in the same
 * cycle; stores are a one-cycle strobe taken on the closing edge.
 */

`timescale 1ns/1ps

module riscvCore
#(
    parameter riscvPkg::wordT RESET_VECTOR = 32'h0000_0000
)
(
    input  logic           clk,
    input  logic           reset,
    output riscvPkg::wordT instrAddr,
    input  riscvPkg::wordT instrData,
    output riscvPkg::wordT memAddr,
    output riscvPkg::wordT memWriteData,
    output logic           memWrite,
    output logic           memRead,
    input  riscvPkg::wordT memReadData
);

    riscvPkg::wordT      pc;
    riscvPkg::wordT      nextPc;
    riscvPkg::wordT      pcPlus4;
    riscvPkg::wordT      pcPlusImm;
    riscvPkg::wordT      imm;
    riscvPkg::wordT      rs1Data;
    riscvPkg::wordT      rs2Data;
    riscvPkg::wordT      aluA;
    riscvPkg::wordT      aluB;
    riscvPkg::wordT      aluResult;
    riscvPkg::wordT      writeBackData;
    logic                aluZero;
    logic                branchTaken;

    riscvPkg::resultSrcT resultSrc;
    riscvPkg::pcSrcT     pcSrc;
    riscvPkg::immTypeT   immType;
    riscvPkg::aluOpT     aluOp;
    logic                aluSrcA;
    logic                aluSrcB;
    logic                ctrlMemWrite;
    logic                ctrlMemRead;
    logic                ctrlRegWrite;
    logic                branchNotEqual;

    controlUnit controlUnit_i
    (
        .opcode         (riscvPkg::opcodeT'(instrData[6:0])),
        .func3          (instrData[14:12]),
        .resultSrc      (resultSrc),
        .pcSrc          (pcSrc),
        .aluSrcA        (aluSrcA),
        .aluSrcB        (aluSrcB),
        .immType        (immType),
        .aluOp          (aluOp),
        .memWrite       (ctrlMemWrite),
        .memRead        (ctrlMemRead),
        .regWrite       (ctrlRegWrite),
        .branchNotEqual (branchNotEqual)
    );

    immediateGen immediateGen_i
    (
        .instr   (instrData),
        .immType (immType),
        .imm     (imm)
    );

    registerFile registerFile_i
    (
        .clk         (clk),
        .reset       (reset),
        .readAddr1   (instrData[19:15]),
        .readAddr2   (instrData[24:20]),
        .readData1   (rs1Data),
        .readData2   (rs2Data),
        .writeAddr   (instrData[11:7]),
        .writeData   (writeBackData),
        .writeEnable (ctrlRegWrite && !reset)
    );

    // Operand muxes, PC feeds AUIPC
    assign aluA = aluSrcA ? pc : rs1Data;
    assign aluB = aluSrcB ? imm : rs2Data;

    alu alu_i
    (
        .aluOp      (aluOp),
        .func3      (instrData[14:12]),
        .func7Bit   (instrData[30]),
        .operandImm (aluSrcB),
        .a          (aluA),
        .b          (aluB),
        .result     (aluResult),
        .zero       (aluZero)
    );

    always_comb
    begin
        case (resultSrc)
            riscvPkg::RES_MEM: writeBackData = memReadData;
            riscvPkg::RES_PC4: writeBackData = pcPlus4;
            riscvPkg::RES_IMM: writeBackData = imm;
            default:           writeBackData = aluResult;
        endcase
    end

    // Next PC
    assign pcPlus4     = pc + 32'd4;
    assign pcPlusImm   = pc + imm;
    assign branchTaken = aluZero ^ branchNotEqual;

    always_comb
    begin
        case (pcSrc)
            riscvPkg::PC_BRANCH: nextPc = branchTaken ? pcPlusImm : pcPlus4;
            riscvPkg::PC_JAL:    nextPc = pcPlusImm;
            riscvPkg::PC_JALR:   nextPc = {aluResult[31:1], 1'b0};
            default:             nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= RESET_VECTOR;
        end
        else
        begin
            pc <= nextPc;
        end
    end

    assign instrAddr    = pc;
    assign memAddr      = aluResult;
    assign memWriteData = rs2Data;
    // No memory traffic while held in reset
    assign memWrite     = ctrlMemWrite && !reset;
    assign memRead      = ctrlMemRead && !reset;

endmodule

// File: tests/clockGen.sv
/*
 * Testbench clock source
 * Free-running clock of the given period, low at time zero.
 */

`timescale 1ns/1ps

module clockGen
#(
    parameter int PERIOD_NS = 40
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// File: tests/riscvCore_assert.sv
/*
 * Protocol assertions for the single-cycle core
 * Bound into riscvCore; checks the memory strobes and PC alignment.
 */

`timescale 1ns/1ps

module riscvCore_assert
(
    input logic           clk,
    input logic           reset,
    input riscvPkg::wordT instrAddr,
    input logic           memWrite,
    input logic           memRead
);

    // One data access per cycle at most
    noReadAndWrite: assert property (@(posedge clk) !(memWrite && memRead))
        else $error("memWrite and memRead are high in the same cycle");

    noWriteInReset: assert property (@(posedge clk) reset |-> !memWrite)
        else $error("memWrite is high while reset is asserted");

    // PC is undefined before the first reset edge
    alignedPc: assert property (@(posedge clk) disable iff (reset) instrAddr[1:0] == 2'b00)
        else $error("instrAddr is not word aligned");

endmodule

// File: tests/riscvCoreTb.sv
/*
 * Testbench for the single-cycle RV32I subset core
 * Builds a random forward-flowing program, runs it on the DUT and on an
 * instruction-level model in lockstep, and compares PC and stores.
 */

`timescale 1ns/1ps

module riscvCoreTb;

    localparam int PROG_WORDS = 200;
    localparam int DATA_WORDS = 64;
    localparam int MAX_CYCLES = 2000;
    localparam riscvPkg::wordT HALT_ADDR = 32'((PROG_WORDS - 1) * 4);

    logic           clk;
    logic           reset;
    riscvPkg::wordT instrAddr;
    riscvPkg::wordT instrData;
    riscvPkg::wordT memAddr;
    riscvPkg::wordT memWriteData;
    logic           memWrite;
    logic           memRead;
    riscvPkg::wordT memReadData;

    riscvPkg::wordT imem [PROG_WORDS];
    riscvPkg::wordT dmem [DATA_WORDS];
    riscvPkg::wordT modelMem [DATA_WORDS];
    riscvPkg::wordT modelRegs [32];
    riscvPkg::wordT modelPc;
    riscvPkg::wordT storeAddrQ [$];
    riscvPkg::wordT storeDataQ [$];
    logic           modelLoad;
    int             modelStores;
    int             storesSeen;
    int             cycles;
    logic           halted;
    logic [31:0]    lfsr;

    clockGen #(.PERIOD_NS(40)) clockGen_i (.clk(clk));

    riscvCore #(.RESET_VECTOR(32'h0000_0000)) dut_i
    (
        .clk          (clk),
        .reset        (reset),
        .instrAddr    (instrAddr),
        .instrData    (instrData),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWrite     (memWrite),
        .memRead      (memRead),
        .memReadData  (memReadData)
    );

    bind riscvCore riscvCore_assert riscvCoreAssert_i
    (
        .clk       (clk),
        .reset     (reset),
        .instrAddr (instrAddr),
        .memWrite  (memWrite),
        .memRead   (memRead)
    );

    // Both memories answer within the same cycle
    // Fetches beyond the program return zero
    assign instrData   = (instrAddr < HALT_ADDR + 32'd4) ? imem[instrAddr[9:2]] : 32'h0;
    assign memReadData = dmem[memAddr[7:2]];

    always @(posedge clk)
    begin
        if (memWrite)
        begin
            dmem[memAddr[7:2]] <= memWriteData;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    // Steps once for every bit taken
    function automatic logic [31:0] randBits(int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic int randBelow(int n);
        return int'(randBits(16)) % n;
    endfunction

    function automatic riscvPkg::wordT fillWord(int idx);
        riscvPkg::wordT addr;
        addr = 32'(idx * 4);
        return (addr * 32'h9E37_79B9) ^ 32'hC3A5_0F1E;
    endfunction

    // Instruction encoders
    function automatic riscvPkg::wordT encodeI(logic [11:0] imm, logic [4:0] rs1,
                                               logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic riscvPkg::wordT encodeS(logic [11:0] imm, logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], riscvPkg::STORE};
    endfunction

    function automatic riscvPkg::wordT encodeB(logic [12:0] imm, logic [4:0] rs2,
                                               logic [4:0] rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], riscvPkg::BRANCH};
    endfunction

    function automatic riscvPkg::wordT encodeJ(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, riscvPkg::JAL};
    endfunction

    function automatic riscvPkg::wordT randomInstr(int idx);
        int          kind;
        int          span;
        int          offsetBytes;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm12;
        logic [19:0] upper;
        logic [2:0]  f3;
        kind  = randBelow(20);
        rd    = 5'(randBits(5));
        rs1   = 5'(randBits(5));
        rs2   = 5'(randBits(5));
        imm12 = 12'(randBits(12));
        upper = 20'(randBits(20));
        f3    = 3'(randBits(3));
        // Control flow only jumps forward by up to eight words
        span        = (PROG_WORDS - 1 - idx < 8) ? PROG_WORDS - 1 - idx : 8;
        offsetBytes = (1 + randBelow(span)) * 4;
        case (kind)
            0:          return {upper, rd, imm12[0] ? 7'b0001111 : 7'b1110011};
            1, 2, 3:    return {1'b0, imm12[10], 5'b0, rs2, rs1, f3, rd, riscvPkg::OP};
            4, 5, 6:
            begin
                if (f3 == 3'b001 || f3 == 3'b101)
                begin
                    imm12 = {1'b0, imm12[10], 5'b0, imm12[4:0]};
                end
                return encodeI(imm12, rs1, f3, rd, riscvPkg::OP_IMM);
            end
            7:          return {upper, rd, riscvPkg::LUI};
            8:          return {upper, rd, riscvPkg::AUIPC};
            9, 10:      return encodeI({4'b0, imm12[5:0], 2'b00}, 5'd0, 3'b010, rd, riscvPkg::LOAD);
            11, 12, 13, 14, 15:
            begin
                return encodeS({4'b0, imm12[5:0], 2'b00}, rs2);
            end
            16, 17:     return encodeB(13'(offsetBytes), rs2, rs1, {2'b00, imm12[0]});
            18:         return encodeJ(21'(offsetBytes), rd);
            default:    return encodeI(12'(idx * 4 + offsetBytes), 5'd0, 3'b000, rd, riscvPkg::JALR);
        endcase
    endfunction

    function automatic riscvPkg::wordT aluModel(logic [2:0] f3, logic alt,
                                                riscvPkg::wordT a, riscvPkg::wordT b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // Executes the instruction at modelPc on the reference state
    task automatic stepModel();
        riscvPkg::wordT instr;
        riscvPkg::wordT rs1Val;
        riscvPkg::wordT rs2Val;
        riscvPkg::wordT immI;
        riscvPkg::wordT immS;
        riscvPkg::wordT immB;
        riscvPkg::wordT immJ;
        riscvPkg::wordT immU;
        riscvPkg::wordT addr;
        riscvPkg::wordT result;
        riscvPkg::wordT nextPc;
        logic [2:0]     f3;
        logic           writeRd;
        instr     = (modelPc < HALT_ADDR + 32'd4) ? imem[modelPc[9:2]] : 32'h0;
        f3        = instr[14:12];
        rs1Val    = modelRegs[instr[19:15]];
        rs2Val    = modelRegs[instr[24:20]];
        immI      = {{20{instr[31]}}, instr[31:20]};
        immS      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        immB      = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        immJ      = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        immU      = {instr[31:12], 12'b0};
        nextPc    = modelPc + 32'd4;
        result    = '0;
        writeRd   = 1'b1;
        modelLoad = 1'b0;
        case (instr[6:0])
            riscvPkg::OP:     result = aluModel(f3, instr[30], rs1Val, rs2Val);
            riscvPkg::OP_IMM: result = aluModel(f3, f3 == 3'b101 && instr[30], rs1Val, immI);
            riscvPkg::LUI:    result = immU;
            riscvPkg::AUIPC:  result = modelPc + immU;
            riscvPkg::LOAD:
            begin
                modelLoad = 1'b1;
                addr      = rs1Val + immI;
                result    = modelMem[addr[7:2]];
            end
            riscvPkg::STORE:
            begin
                writeRd = 1'b0;
                addr    = rs1Val + immS;
                modelMem[addr[7:2]] = rs2Val;
                storeAddrQ.push_back(addr);
                storeDataQ.push_back(rs2Val);
                modelStores++;
            end
            riscvPkg::BRANCH:
            begin
                writeRd = 1'b0;
                if ((f3 == 3'b000 && rs1Val == rs2Val) || (f3 == 3'b001 && rs1Val != rs2Val))
                begin
                    nextPc = modelPc + immB;
                end
            end
            riscvPkg::JAL:
            begin
                result = modelPc + 32'd4;
                nextPc = modelPc + immJ;
            end
            riscvPkg::JALR:
            begin
                result = modelPc + 32'd4;
                nextPc = (rs1Val + immI) & ~32'd1;
            end
            default:          writeRd = 1'b0;
        endcase
        if (writeRd && instr[11:7] != 5'd0)
        begin
            modelRegs[instr[11:7]] = result;
        end
        modelPc = nextPc;
    endtask

    task automatic abortRun(string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "riscvCoreTb stopped on the first error");
    endtask

    task automatic checkPc(riscvPkg::wordT actual, riscvPkg::wordT expected);
        if (actual !== expected)
        begin
            abortRun($sformatf("** Error at %0t: instrAddr 0x%08h, expected 0x%08h",
                               $time, actual, expected));
        end
    endtask

    task automatic checkMemRead(logic actual, logic expected);
        if (actual !== expected)
        begin
            abortRun($sformatf("** Error at %0t: memRead %0b, expected %0b",
                               $time, actual, expected));
        end
    endtask

    task automatic checkStore(riscvPkg::wordT addr, riscvPkg::wordT data);
        riscvPkg::wordT expAddr;
        riscvPkg::wordT expData;
        if (storeAddrQ.size() == 0)
        begin
            abortRun("The DUT wrote memory where the model executed no store");
        end
        else
        begin
            expAddr = storeAddrQ.pop_front();
            expData = storeDataQ.pop_front();
            if (addr !== expAddr || data !== expData)
            begin
                abortRun($sformatf("** Error at %0t: store %08h to %08h, expected %08h to %08h",
                                   $time, data, addr, expData, expAddr));
            end
            else
            begin
                storesSeen++;
            end
        end
    endtask

    initial
    begin
        reset       = 1'b1;
        lfsr        = 32'hb1e8;
        modelStores = 0;
        storesSeen  = 0;
        cycles      = 0;
        halted      = 1'b0;
        modelLoad   = 1'b0;
        modelPc     = 32'h0;
        for (int i = 0; i < PROG_WORDS - 1; i++)
        begin
            imem[i] = randomInstr(i);
        end
        // JAL x0 to itself halts the program
        imem[PROG_WORDS - 1] = encodeJ(21'd0, 5'd0);
        for (int i = 0; i < DATA_WORDS; i++)
        begin
            dmem[i]     = fillWord(i);
            modelMem[i] = fillWord(i);
        end
        for (int i = 0; i < 32; i++)
        begin
            modelRegs[i] = '0;
        end

        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // Lockstep run sampled on the falling edge
        while (!halted && cycles < MAX_CYCLES)
        begin
            @(negedge clk);
            checkPc(instrAddr, modelPc);
            if (modelPc == HALT_ADDR)
            begin
                halted = 1'b1;
            end
            else
            begin
                stepModel();
                checkMemRead(memRead, modelLoad);
                if (memWrite)
                begin
                    checkStore(memAddr, memWriteData);
                end
                if (storeAddrQ.size() != 0)
                begin
                    abortRun("The model executed a store but the DUT left memWrite low");
                end
                cycles++;
            end
        end

        if (!halted)
        begin
            abortRun("Timeout: the core did not reach the halt address within 2000 cycles");
        end
        else if (storesSeen != modelStores)
        begin
            abortRun($sformatf("** Error at %0t: %0d stores seen, expected %0d",
                               $time, storesSeen, modelStores));
        end
        else
        begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// File: filelist.f
verilog/riscvPkg.sv
verilog/controlUnit.sv
verilog/alu.sv
verilog/registerFile.sv
verilog/immediateGen.sv
verilog/riscvCore.sv
tests/clockGen.sv
tests/riscvCore_assert.sv
tests/riscvCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the riscvCore testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module riscvCoreTb -f filelist.f -o riscvCoreSim \
    && ./obj_dir/riscvCoreSim > sim.log 2>&1
cat sim.log 2>/dev/null

grep -qx "STATUS: PASS" sim.log 2>/dev/null && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }
